// File: list.f
+incdir+.
led_status_pkg.sv
port_status_if.sv
link_sync.sv
flap_detect.sv
led_driver.sv
led_status_regs.sv
led_status_top.sv
led_status_checker.sv
tb_led_status.sv

// File: Bender.yml
package:
  name: led_status

sources:
  - include_dirs:
      - .
    files:
      - led_status_pkg.sv
      - port_status_if.sv
      - link_sync.sv
      - flap_detect.sv
      - led_driver.sv
      - led_status_regs.sv
      - led_status_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - led_status_checker.sv
      - tb_led_status.sv

// File: tb_led_status.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module tb_led_status;

  import led_status_pkg::*;

  localparam int DRIVE_DELAY = 5;
  localparam int WAIT_LIMIT  = 50; // cycles per handshake
  localparam int HOLD_CYCLES = 2;  // response back-pressure
  localparam int SETTLE      = `FLAP_COOLOFF_CYCLES + 10;

  typedef struct {
    string                      name;
    logic [2*`NUM_PORTS-1:0]    pattern;  // {active, aligned}
    logic                       busy;
    control_reg_t               control;
    int                         flap_idx; // signal to toggle, -1 for none
    logic                       do_write;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [9:0]                 lamps;    // {rj45, bracket, board}
    status_reg_t                status;
    axi_resp_e                  resp;
  } test_row_t;

  logic                       clk;
  logic                       rst;
  logic [`NUM_PORTS-1:0]      aligned_raw;
  logic [`NUM_PORTS-1:0]      active_raw;
  logic                       reconfig_busy_raw;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [`AXI_DATA_WIDTH-1:0] wdata;
  logic [`AXI_STRB_WIDTH-1:0] wstrb;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic [`AXI_ADDR_WIDTH-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [`AXI_DATA_WIDTH-1:0] rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;
  logic [`NUM_PORTS-1:0]      led_board;
  logic [`NUM_PORTS-1:0]      led_bracket;
  logic [1:0]                 led_rj45;

  test_row_t rows[$];
  int        error_count;
  int        seed;
  logic      timed_out;

  led_status_top i_led_status_top (.*);

  always #50 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic drive_pattern(input logic [2*`NUM_PORTS-1:0] pattern, input logic busy);
    {active_raw, aligned_raw} = pattern;
    reconfig_busy_raw         = busy;
  endtask

  task automatic note_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
    error_count++;
  endtask

  task automatic check_held_off(input string what, input logic ready);
    if (ready) begin
      $display("slave ready for a new %s while its response was held back", what);
      error_count++;
    end
  endtask

  task automatic axi_write(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                           input logic [`AXI_DATA_WIDTH-1:0] data,
                           input logic [`AXI_STRB_WIDTH-1:0] strb,
                           output axi_resp_e resp);
    int   cyc;
    logic aw_hit;
    logic w_hit;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    resp    = RESP_SLVERR;
    cyc     = 0;
    while ((awvalid || wvalid) && cyc < WAIT_LIMIT) begin
      aw_hit = awvalid && awready; // ready only moves on an edge
      w_hit  = wvalid && wready;
      step();
      if (aw_hit) awvalid = 1'b0;
      if (w_hit) wvalid = 1'b0;
      cyc++;
    end
    if (awvalid || wvalid) begin
      awvalid = 1'b0;
      wvalid  = 1'b0;
      note_timeout("write address or data never accepted");
      return;
    end
    cyc = 0;
    while (!bvalid && cyc < WAIT_LIMIT) begin
      step();
      cyc++;
    end
    if (!bvalid) begin
      note_timeout("no write response");
      return;
    end
    repeat (HOLD_CYCLES) begin // response held back
      check_held_off("write address or data", awready || wready);
      step();
    end
    bready = 1'b1;
    resp   = axi_resp_e'(bresp);
    step();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                          output logic [`AXI_DATA_WIDTH-1:0] data,
                          output axi_resp_e resp);
    int cyc;
    araddr  = addr;
    arvalid = 1'b1;
    data    = '0;
    resp    = RESP_SLVERR;
    cyc     = 0;
    while (!arready && cyc < WAIT_LIMIT) begin
      step();
      cyc++;
    end
    if (!arready) begin
      arvalid = 1'b0;
      note_timeout("read address never accepted");
      return;
    end
    step();
    arvalid = 1'b0;
    cyc     = 0;
    while (!rvalid && cyc < WAIT_LIMIT) begin
      step();
      cyc++;
    end
    if (!rvalid) begin
      note_timeout("no read data");
      return;
    end
    repeat (HOLD_CYCLES) begin // response held back
      check_held_off("read address", arready);
      step();
    end
    rready = 1'b1;
    data   = rdata;
    resp   = axi_resp_e'(rresp);
    step();
    rready = 1'b0;
  endtask

  task automatic check_status(input string name, input status_reg_t exp, input status_reg_t act);
    if (act !== exp) begin
      $display("Fail %s status: expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_control(input string name, input control_reg_t exp,
                               input control_reg_t act);
    if (act !== exp) begin
      $display("Fail %s control: expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (act !== exp) begin
      $display("Fail %s resp: expected %0d actual %0d", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_lamps(input string name, input logic [9:0] exp);
    if ({led_rj45, led_bracket, led_board} !== exp) begin
      $display("Fail %s lamps: expected %b actual %b", name, exp,
               {led_rj45, led_bracket, led_board});
      error_count++;
    end
  endtask

  task automatic check_blink(input string name, input logic saw_on, input logic saw_off);
    if (!(saw_on && saw_off)) begin
      $display("%s: the lamp did not blink while its signal was flapping", name);
      error_count++;
    end
  endtask

  // steady lamp pins, active low
  function automatic logic [9:0] lamps_for(input logic [2*`NUM_PORTS-1:0] pattern,
                                           input logic busy, input control_reg_t control);
    if (control.lamp_test) return '0;
    return {1'b1, ~busy, ~pattern};
  endfunction

  function automatic status_reg_t status_for(input logic [2*`NUM_PORTS-1:0] pattern,
                                             input logic busy);
    status_reg_t s;
    s               = '0;
    s.aligned       = pattern[`NUM_PORTS-1:0];
    s.active        = pattern[2*`NUM_PORTS-1:`NUM_PORTS];
    s.reconfig_busy = busy;
    return s;
  endfunction

  task automatic add_row(input string name, input logic [7:0] pattern, input logic busy,
                         input control_reg_t control, input int flap_idx, input logic do_write,
                         input logic [3:0] addr, input logic [9:0] lamps,
                         input status_reg_t status, input axi_resp_e resp);
    test_row_t row;
    row = '{name, pattern, busy, control, flap_idx, do_write, addr, lamps, status, resp};
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [31:0] rnd_pat;
    logic [31:0] rnd_busy;
    add_row("reset_idle", 8'h00, 1'b0, 32'h0, -1, 1'b0, REG_STATUS, 10'h3ff, 32'h0, RESP_OKAY);
    add_row("steady_pattern", 8'h5a, 1'b1, 32'h0, -1, 1'b0, REG_STATUS, 10'h2a5, 32'h1005a,
            RESP_OKAY);
    add_row("flap_blink", 8'h33, 1'b0, 32'h0, 2, 1'b0, REG_STATUS, 10'h3cc, 32'h33, RESP_OKAY);
    add_row("lamp_test", 8'h33, 1'b0, 32'h1, -1, 1'b0, REG_CONTROL, 10'h000, 32'h33,
            RESP_OKAY);
    add_row("lamp_test_clear", 8'h33, 1'b0, 32'h0, -1, 1'b0, REG_STATUS, 10'h3cc, 32'h33,
            RESP_OKAY);
    add_row("blink_disable_flap", 8'h96, 1'b1, 32'h2, 5, 1'b0, REG_STATUS, 10'h269, 32'h10096,
            RESP_OKAY);
    add_row("write_unmapped", 8'h96, 1'b1, 32'h2, -1, 1'b1, 4'h8, 10'h269, 32'h10096,
            RESP_SLVERR);
    add_row("write_status", 8'h96, 1'b1, 32'h2, -1, 1'b1, REG_STATUS, 10'h269, 32'h10096,
            RESP_SLVERR);
    add_row("read_unmapped", 8'h96, 1'b1, 32'h2, -1, 1'b0, 4'hc, 10'h269, 32'h10096,
            RESP_SLVERR);
    rnd_pat  = $random(seed);
    rnd_busy = $random(seed);
    add_row("random_background", rnd_pat[7:0], rnd_busy[0], 32'h0, -1, 1'b0, REG_STATUS,
            lamps_for(rnd_pat[7:0], rnd_busy[0], 32'h0),
            status_for(rnd_pat[7:0], rnd_busy[0]), RESP_OKAY);
  endtask

  task automatic run_row(input test_row_t row);
    logic [`AXI_DATA_WIDTH-1:0] data;
    axi_resp_e                  resp;
    logic [2*`NUM_PORTS-1:0]    flipped;
    logic [2*`NUM_PORTS-1:0]    pins;
    logic                       saw_on;
    logic                       saw_off;
    status_reg_t                mid;
    drive_pattern(row.pattern, row.busy);
    axi_write(REG_CONTROL, row.control, '1, resp);
    check_resp({row.name, " control write"}, RESP_OKAY, resp);
    repeat (SETTLE) step();
    if (row.flap_idx >= 0) begin
      flipped = row.pattern ^ (8'd1 << row.flap_idx);
      drive_pattern(flipped, row.busy);
      repeat (4) step(); // sync, detector and driver latency
      axi_read(REG_STATUS, data, resp);
      mid = row.status ^ (32'd1 << row.flap_idx);
      mid = mid | (32'd1 << (row.flap_idx + 8)); // flap bits sit 8 above levels
      check_status({row.name, " mid flap"}, mid, data);
      saw_on  = 1'b0;
      saw_off = 1'b0;
      repeat (3 * `BLINK_HALF_PERIOD) begin
        pins = {led_bracket, led_board};
        if (row.control.blink_disable) begin
          check_lamps({row.name, " raw level"}, lamps_for(flipped, row.busy, row.control));
        end else begin
          saw_on  = saw_on || !pins[row.flap_idx];
          saw_off = saw_off || pins[row.flap_idx];
        end
        step();
      end
      if (!row.control.blink_disable) check_blink(row.name, saw_on, saw_off);
      drive_pattern(row.pattern, row.busy);
      repeat (SETTLE) step();
    end
    check_lamps({row.name, " steady"}, row.lamps);
    if (row.do_write) begin
      // inverted fields show up in control if the write is wrongly taken
      axi_write(row.addr, {{(`AXI_DATA_WIDTH-2){1'b0}}, ~row.control[1:0]}, '1, resp);
      check_resp(row.name, row.resp, resp);
    end else begin
      axi_read(row.addr, data, resp);
      check_resp(row.name, row.resp, resp);
      if (resp == RESP_OKAY && row.addr == REG_STATUS) check_status(row.name, row.status, data);
    end
    axi_read(REG_CONTROL, data, resp);
    check_control({row.name, " readback"}, row.control, data);
  endtask

  initial begin
    int tests_run;
    int tests_failed;
    int errors_before;
    int assert_failures;
    clk               = 1'b0;
    rst               = 1'b1;
    aligned_raw       = '0;
    active_raw        = '0;
    reconfig_busy_raw = 1'b0;
    awaddr            = '0;
    awvalid           = 1'b0;
    wdata             = '0;
    wstrb             = '0;
    wvalid            = 1'b0;
    bready            = 1'b0;
    araddr            = '0;
    arvalid           = 1'b0;
    rready            = 1'b0;
    error_count       = 0;
    timed_out         = 1'b0;
    seed              = 60022;
    tests_run         = 0;
    tests_failed      = 0;
    build_table();
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    check_lamps("after reset", 10'h3ff);
    foreach (rows[i]) begin
      errors_before = error_count;
      run_row(rows[i]);
      tests_run++;
      if (error_count == errors_before) begin
        $display("%s: ok", rows[i].name);
      end else begin
        tests_failed++;
        $display("%s: %0d errors", rows[i].name, error_count - errors_before);
      end
      if (timed_out) break;
    end
    assert_failures = i_led_status_top.i_led_status_checker.fail_count;
    $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures", tests_run,
             tests_failed, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: led_status_checker.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module led_status_checker (
  input wire                       clk,
  input wire                       rst,
  input wire [`AXI_ADDR_WIDTH-1:0] awaddr,
  input wire                       awvalid,
  input wire                       awready,
  input wire [`AXI_DATA_WIDTH-1:0] wdata,
  input wire                       wvalid,
  input wire                       wready,
  input wire [1:0]                 bresp,
  input wire                       bvalid,
  input wire                       bready,
  input wire [`AXI_ADDR_WIDTH-1:0] araddr,
  input wire                       arvalid,
  input wire                       arready,
  input wire [`AXI_DATA_WIDTH-1:0] rdata,
  input wire [1:0]                 rresp,
  input wire                       rvalid,
  input wire                       rready,
  input wire [`NUM_PORTS-1:0]      led_board,
  input wire [`NUM_PORTS-1:0]      led_bracket,
  input wire [1:0]                 led_rj45
);

  int fail_count = 0; // failed assertions so far

  // a raised valid keeps its payload until the transfer
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("aw valid dropped or address changed before ready");
      fail_count++;
    end

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else begin
      $error("w valid dropped or data changed before ready");
      fail_count++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("b valid dropped or response changed before ready");
      fail_count++;
    end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("ar valid dropped or address changed before ready");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $error("r valid dropped or payload changed before ready");
      fail_count++;
    end

  // lamps dark through reset and the cycle after
  a_lamps_off: assert property (@(posedge clk)
    rst |=> (led_board == '1) && (led_bracket == '1) && (led_rj45 == '1))
    else begin
      $error("lamp pin driven low around reset");
      fail_count++;
    end

  a_bresp_legal: assert property (@(posedge clk) disable iff (rst)
    bresp inside {2'b00, 2'b10})
    else begin
      $error("bresp carries a reserved code");
      fail_count++;
    end

  a_rresp_legal: assert property (@(posedge clk) disable iff (rst)
    rresp inside {2'b00, 2'b10})
    else begin
      $error("rresp carries a reserved code");
      fail_count++;
    end

endmodule

bind led_status_top led_status_checker i_led_status_checker (.*);

`default_nettype wire

// File: led_status_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module led_status_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [`NUM_PORTS-1:0]       aligned_raw,
  input  wire [`NUM_PORTS-1:0]       active_raw,
  input  wire                        reconfig_busy_raw,
  input  wire [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire [`AXI_DATA_WIDTH-1:0]  wdata,
  input  wire [`AXI_STRB_WIDTH-1:0]  wstrb,
  input  wire                        wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  wire                        bready,
  input  wire [`AXI_ADDR_WIDTH-1:0]  araddr,
  input  wire                        arvalid,
  output logic                       arready,
  output logic [`AXI_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  wire                        rready,
  output logic [`NUM_PORTS-1:0]      led_board,
  output logic [`NUM_PORTS-1:0]      led_bracket,
  output logic [1:0]                 led_rj45
);

  import led_status_pkg::*;

  logic         reconfig_busy;
  control_reg_t control;

  port_status_if status ();

  link_sync i_link_sync (
    .clk               (clk),
    .rst               (rst),
    .aligned_raw       (aligned_raw),
    .active_raw        (active_raw),
    .reconfig_busy_raw (reconfig_busy_raw),
    .status            (status),
    .reconfig_busy     (reconfig_busy)
  );

  // lower half watches aligned, upper half watches active
  for (genvar g = 0; g < 2 * `NUM_PORTS; g++) begin : g_flap
    if (g < `NUM_PORTS) begin : g_aligned
      flap_detect i_flap_detect (
        .clk   (clk),
        .rst   (rst),
        .level (status.aligned[g]),
        .flap  (status.aligned_flap[g])
      );
    end else begin : g_active
      flap_detect i_flap_detect (
        .clk   (clk),
        .rst   (rst),
        .level (status.active[g - `NUM_PORTS]),
        .flap  (status.active_flap[g - `NUM_PORTS])
      );
    end
  end

  led_status_regs i_led_status_regs (
    .clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .status        (status),
    .reconfig_busy (reconfig_busy),
    .control       (control)
  );

  led_driver i_led_driver (
    .clk           (clk),
    .rst           (rst),
    .status        (status),
    .control       (control),
    .reconfig_busy (reconfig_busy),
    .led_board     (led_board),
    .led_bracket   (led_bracket),
    .led_rj45      (led_rj45)
  );

endmodule

`default_nettype wire

// File: led_status_regs.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module led_status_regs (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire [`AXI_DATA_WIDTH-1:0]  wdata,
  input  wire [`AXI_STRB_WIDTH-1:0]  wstrb,
  input  wire                        wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  wire                        bready,
  input  wire [`AXI_ADDR_WIDTH-1:0]  araddr,
  input  wire                        arvalid,
  output logic                       arready,
  output logic [`AXI_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  wire                        rready,
  port_status_if.sink                status,
  input  wire                        reconfig_busy,
  output led_status_pkg::control_reg_t control
);

  import led_status_pkg::*;

  axi_wr_state_e              wr_state;
  axi_rd_state_e              rd_state;
  logic                       aw_got;   // address held, data still missing
  logic                       w_got;    // data held, address still missing
  logic [`AXI_ADDR_WIDTH-1:0] awaddr_q;
  logic [`AXI_DATA_WIDTH-1:0] wdata_q;
  logic                       wstrb0_q;
  logic                       aw_hs;
  logic                       w_hs;
  logic                       wr_go;
  logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
  logic [`AXI_DATA_WIDTH-1:0] wr_data;
  logic                       wr_strb0;
  status_reg_t                status_word;

  assign awready = (wr_state == WR_IDLE) || (wr_state == WR_DATA && !aw_got);
  assign wready  = (wr_state == WR_IDLE) || (wr_state == WR_DATA && !w_got);
  assign bvalid  = (wr_state == WR_RESP);
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign wr_go   = (aw_hs || aw_got) && (w_hs || w_got); // both halves in hand

  // take whichever half arrives this cycle, else the held copy
  assign wr_addr  = aw_hs ? awaddr : awaddr_q;
  assign wr_data  = w_hs ? wdata : wdata_q;
  assign wr_strb0 = w_hs ? wstrb[0] : wstrb0_q;

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awaddr_q <= awaddr;
    end
    if (w_hs) begin
      wdata_q  <= wdata;
      wstrb0_q <= wstrb[0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      bresp    <= RESP_OKAY;
      control  <= '0;
    end else begin
      case (wr_state)
        WR_IDLE, WR_DATA: begin
          if (wr_go) begin
            wr_state <= WR_RESP;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            case (reg_addr_e'(wr_addr))
              REG_CONTROL: begin
                if (wr_strb0) begin // only byte 0 carries fields
                  control.lamp_test     <= wr_data[0];
                  control.blink_disable <= wr_data[1];
                end
                bresp <= RESP_OKAY;
              end
              default: bresp <= RESP_SLVERR; // status is read only
            endcase
          end else if (aw_hs || w_hs) begin
            wr_state <= WR_DATA;
            aw_got   <= aw_got || aw_hs;
            w_got    <= w_got || w_hs;
          end
        end
        WR_RESP: begin
          if (bready) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_comb begin
    status_word               = '0;
    status_word.aligned       = status.aligned;
    status_word.active        = status.active;
    status_word.aligned_flap  = status.aligned_flap;
    status_word.active_flap   = status.active_flap;
    status_word.reconfig_busy = reconfig_busy;
  end

  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_RESP);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
      rresp    <= RESP_OKAY;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (arvalid) begin
            rd_state <= RD_RESP;
            case (reg_addr_e'(araddr))
              REG_STATUS, REG_CONTROL: rresp <= RESP_OKAY;
              default:                 rresp <= RESP_SLVERR;
            endcase
          end
        end
        RD_RESP: begin
          if (rready) begin
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // status sampled live at the ar transfer
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      case (reg_addr_e'(araddr))
        REG_STATUS:  rdata <= status_word;
        REG_CONTROL: rdata <= control;
        default:     rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: led_driver.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module led_driver (
  input  wire                          clk,
  input  wire                          rst,
  port_status_if.sink                  status,
  input  wire led_status_pkg::control_reg_t control,
  input  wire                          reconfig_busy,
  output logic [`NUM_PORTS-1:0]        led_board,
  output logic [`NUM_PORTS-1:0]        led_bracket,
  output logic [1:0]                   led_rj45
);

  logic [31:0]             blink_cnt;
  logic                    blink;
  logic [2*`NUM_PORTS-1:0] level;
  logic [2*`NUM_PORTS-1:0] flap;
  logic [2*`NUM_PORTS-1:0] lamp_on; // active high, before pin inversion

  assign level = {status.active, status.aligned};
  assign flap  = {status.active_flap, status.aligned_flap};

  // free-running blink phase shared by all lamps
  always_ff @(posedge clk) begin
    if (rst) begin
      blink_cnt <= '0;
      blink     <= 1'b0;
    end else if (blink_cnt == `BLINK_HALF_PERIOD - 32'd1) begin
      blink_cnt <= '0;
      blink     <= ~blink;
    end else begin
      blink_cnt <= blink_cnt + 32'd1;
    end
  end

  always_comb begin
    for (int i = 0; i < 2 * `NUM_PORTS; i++) begin
      if (control.lamp_test) begin
        lamp_on[i] = 1'b1;
      end else if (flap[i] && !control.blink_disable) begin
        lamp_on[i] = blink;
      end else begin
        lamp_on[i] = level[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led_board   <= '1; // all off
      led_bracket <= '1;
      led_rj45    <= '1;
    end else begin
      led_board   <= ~lamp_on[`NUM_PORTS-1:0];
      led_bracket <= ~lamp_on[2*`NUM_PORTS-1:`NUM_PORTS];
      led_rj45[0] <= ~(reconfig_busy || control.lamp_test);
      led_rj45[1] <= ~control.lamp_test; // otherwise unused on the card
    end
  end

endmodule

`default_nettype wire

// File: flap_detect.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module flap_detect #(
  parameter int unsigned COOLOFF = `FLAP_COOLOFF_CYCLES
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  level,
  output logic flap
);

  import led_status_pkg::*;

  flap_state_e state;
  logic        level_q;  // previous level for edge detect
  logic [31:0] count;    // quiet cycles left
  logic        change;

  assign change = level ^ level_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= STABLE;
      level_q <= 1'b0;
      count   <= '0;
    end else begin
      level_q <= level;
      if (change) begin
        state <= FLAPPING;
        count <= 32'(COOLOFF - 1); // flag spans exactly COOLOFF cycles
      end else if (state == FLAPPING) begin
        if (count == '0) begin
          state <= STABLE;
        end else begin
          count <= count - 32'd1;
        end
      end
    end
  end

  assign flap = (state == FLAPPING);

endmodule

`default_nettype wire

// File: link_sync.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

module link_sync (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [`NUM_PORTS-1:0] aligned_raw,
  input  wire [`NUM_PORTS-1:0] active_raw,
  input  wire                  reconfig_busy_raw,
  port_status_if.sync          status,
  output logic                 reconfig_busy
);

  logic [`NUM_PORTS-1:0] aligned_meta; // first stage, may go metastable
  logic [`NUM_PORTS-1:0] active_meta;
  logic                  busy_meta;

  always_ff @(posedge clk) begin
    if (rst) begin
      aligned_meta   <= '0;
      active_meta    <= '0;
      busy_meta      <= 1'b0;
      status.aligned <= '0;
      status.active  <= '0;
      reconfig_busy  <= 1'b0;
    end else begin
      aligned_meta   <= aligned_raw;
      active_meta    <= active_raw;
      busy_meta      <= reconfig_busy_raw;
      status.aligned <= aligned_meta; // second stage
      status.active  <= active_meta;
      reconfig_busy  <= busy_meta;
    end
  end

endmodule

`default_nettype wire

// File: port_status_if.sv
`default_nettype none
`timescale 1ns/10ps

`include "led_status_settings.svh"

interface port_status_if;

  logic [`NUM_PORTS-1:0] aligned;      // synchronized levels
  logic [`NUM_PORTS-1:0] active;
  logic [`NUM_PORTS-1:0] aligned_flap; // one bit per flap detector
  logic [`NUM_PORTS-1:0] active_flap;

  modport sync (output aligned, output active);

  modport detect (
    input  aligned,
    input  active,
    output aligned_flap,
    output active_flap
  );

  modport sink (input aligned, input active, input aligned_flap, input active_flap);

endinterface

`default_nettype wire

// File: led_status_pkg.sv
`default_nettype none

`include "led_status_settings.svh"

package led_status_pkg;

  typedef enum logic {
    STABLE   = 1'b0,
    FLAPPING = 1'b1
  } flap_state_e;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1, // one of aw/w taken, waiting for the other
    WR_RESP = 2'd2
  } axi_wr_state_e;

  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_RESP = 1'b1
  } axi_rd_state_e;

  typedef enum logic [3:0] {
    REG_STATUS  = 4'h0,
    REG_CONTROL = 4'h4
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  localparam int STATUS_PAD_W = `AXI_DATA_WIDTH - 1 - 4 * `NUM_PORTS;

  // msb first, aligned lands in bits 3:0
  typedef struct packed {
    logic [STATUS_PAD_W-1:0] pad;
    logic                    reconfig_busy;
    logic [`NUM_PORTS-1:0]   active_flap;
    logic [`NUM_PORTS-1:0]   aligned_flap;
    logic [`NUM_PORTS-1:0]   active;
    logic [`NUM_PORTS-1:0]   aligned;
  } status_reg_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-3:0] pad;
    logic                       blink_disable; // bit 1
    logic                       lamp_test;     // bit 0
  } control_reg_t;

endpackage

`default_nettype wire

// File: led_status_settings.svh
`ifndef LED_STATUS_SETTINGS_SVH
`define LED_STATUS_SETTINGS_SVH

// quiet cycles before a link signal counts as settled
`define FLAP_COOLOFF_CYCLES 32'd20

// cycles between blink phase toggles
`define BLINK_HALF_PERIOD 32'd4

// fibre channel ports on the card
`define NUM_PORTS 4

// management bus
`define AXI_ADDR_WIDTH 4
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

`endif
